// ==== design/if_pkg.sv ====
////////////////////////////////////////
// shared definitions for the instruction fetch stage
// widths, opcodes, PC source select and fixed addresses
// every RTL file imports this with a wildcard import
////////////////////////////////////////

package if_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // instruction and address width
  localparam int unsigned XLEN = 32;
  // compressed instruction width
  localparam int unsigned CINSTR_W = 16;
  // capability top is one bit wider so it can reach 2^32
  localparam int unsigned TOP_W = XLEN + 1;

  ////////////////////////////////////////
  // fixed addresses
  ////////////////////////////////////////

  // low bits cleared in mtvec and required zero in the boot address
  localparam int unsigned VEC_ALIGN_BITS = 8;
  // low byte appended to the boot address
  localparam logic [VEC_ALIGN_BITS-1:0] BOOT_OFFSET = 8'h80;

  ////////////////////////////////////////
  // register indices
  ////////////////////////////////////////

  // stack pointer, rd of C.ADDI16SP shares the C.LUI slot
  localparam logic [4:0] REG_SP = 5'd2;
  // 3-bit compressed register fields address x8..x15
  localparam int unsigned RVC_REG_BASE = 8;

  // source of the redirect address
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_JUMP = 2'd1,
    PC_EXC  = 2'd2,
    PC_ERET = 2'd3
  } pc_sel_e;

  // major opcodes produced by the compressed expander
  typedef enum logic [6:0] {
    OP_IMM = 7'h13,
    LUI    = 7'h37,
    OP     = 7'h33,
    JAL    = 7'h6f,
    LOAD   = 7'h03,
    STORE  = 7'h23
  } opcode_e;

endpackage

// ==== design/next_pc_sel.sv ====
////////////////////////////////////////
// redirect address select for the fetch stage
// picks boot, jump, exception or mret address on a PC set
// and asks the CSR file to init mtvec on boot
////////////////////////////////////////

module next_pc_sel import if_pkg::*; (
  input  logic            pc_set_i,
  input  pc_sel_e         pc_mux_i,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic [XLEN-1:0] branch_target_i,
  input  logic [XLEN-1:0] csr_mepc_i,
  input  logic [XLEN-1:0] csr_mtvec_i,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_addr_o,
  output logic            csr_mtvec_init_o
);

  logic [XLEN-1:0] boot_pc;
  logic [XLEN-1:0] exc_pc;

  // boot vector sits at a fixed offset inside the aligned boot region
  assign boot_pc = {boot_addr_i[XLEN-1:VEC_ALIGN_BITS], BOOT_OFFSET};

  // direct mode only, so the trap base is mtvec with its low bits cleared
  assign exc_pc = {csr_mtvec_i[XLEN-1:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: redirect_addr_o = boot_pc;
      PC_JUMP: redirect_addr_o = branch_target_i;
      PC_EXC:  redirect_addr_o = exc_pc;
      // return to the trapped instruction
      PC_ERET: redirect_addr_o = csr_mepc_i;
      default: redirect_addr_o = boot_pc;
    endcase
  end

  // fetch restarts in the same cycle as the PC set
  assign redirect_o = pc_set_i;

  // mtvec starts out as the boot address
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// ==== design/c_expander.sv ====
////////////////////////////////////////
// compressed instruction expander
// rebuilds a subset of RVC as 32-bit instructions
// unsupported encodings are flagged and left as fetched
////////////////////////////////////////

module c_expander import if_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output logic [XLEN-1:0] instr_o,
  output logic            is_compressed_o,
  output logic            illegal_o
);

  logic [CINSTR_W-1:0] c_instr;
  // widened 3-bit register fields
  logic [4:0]          creg_42;
  logic [4:0]          creg_97;

  assign c_instr = instr_i[CINSTR_W-1:0];

  assign creg_42 = 5'(RVC_REG_BASE) + {2'b00, c_instr[4:2]};
  assign creg_97 = 5'(RVC_REG_BASE) + {2'b00, c_instr[9:7]};

  // 32-bit instructions always end in 2'b11
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    // default keeps the word as fetched
    instr_o   = instr_i;
    illegal_o = 1'b0;

    unique case (c_instr[1:0])
      ////////////////////////////////////////
      // quadrant 0
      ////////////////////////////////////////
      2'b00: begin
        case (c_instr[15:13])
          // c.lw -> lw rd', uimm(rs1')
          3'b010: instr_o = {5'b0, c_instr[5], c_instr[12:10], c_instr[6], 2'b00,
                             creg_97, 3'b010, creg_42, LOAD};
          // c.sw -> sw rs2', uimm(rs1')
          3'b110: instr_o = {5'b0, c_instr[5], c_instr[12], creg_42, creg_97, 3'b010,
                             c_instr[11:10], c_instr[6], 2'b00, STORE};
          // c.addi4spn and the all-zero halfword land here
          default: illegal_o = 1'b1;
        endcase
      end

      ////////////////////////////////////////
      // quadrant 1
      ////////////////////////////////////////
      2'b01: begin
        case (c_instr[15:13])
          // c.addi -> addi rd, rd, simm
          3'b000: instr_o = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2], c_instr[11:7],
                             3'b000, c_instr[11:7], OP_IMM};
          // c.li -> addi rd, x0, simm
          3'b010: instr_o = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2], 5'b0,
                             3'b000, c_instr[11:7], OP_IMM};
          3'b011: begin
            // rd == sp is c.addi16sp which is not supported
            // zero immediate is reserved
            if (c_instr[11:7] == REG_SP || {c_instr[12], c_instr[6:2]} == 6'b0) begin
              illegal_o = 1'b1;
            end else begin
              // c.lui -> lui rd, nzimm
              instr_o = {{15{c_instr[12]}}, c_instr[6:2], c_instr[11:7], LUI};
            end
          end
          // c.j -> jal x0, offset
          // offset bits are scattered in the halfword
          3'b101: instr_o = {c_instr[12], c_instr[8], c_instr[10:9], c_instr[6], c_instr[7],
                             c_instr[2], c_instr[11], c_instr[5:3], {9{c_instr[12]}},
                             5'b0, JAL};
          default: illegal_o = 1'b1;
        endcase
      end

      ////////////////////////////////////////
      // quadrant 2
      ////////////////////////////////////////
      2'b10: begin
        // rs2 == 0 selects c.jr, c.jalr or c.ebreak
        if (c_instr[15:13] == 3'b100 && c_instr[6:2] != 5'b0) begin
          if (c_instr[12]) begin
            // c.add -> add rd, rd, rs2
            instr_o = {7'b0, c_instr[6:2], c_instr[11:7], 3'b000, c_instr[11:7], OP};
          end else begin
            // c.mv -> add rd, x0, rs2
            instr_o = {7'b0, c_instr[6:2], 5'b0, 3'b000, c_instr[11:7], OP};
          end
        end else begin
          illegal_o = 1'b1;
        end
      end

      // uncompressed word
      default: begin
        instr_o   = instr_i;
        illegal_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== design/pcc_bounds_check.sv ====
////////////////////////////////////////
// program counter capability check on each fetch
// flags fetches outside the PCC bounds and fetches
// without execute permission in capability mode
////////////////////////////////////////

module pcc_bounds_check import if_pkg::*; (
  input  logic             cheri_pmode_i,
  input  logic [XLEN-1:0]  pcc_base_i,
  input  logic [TOP_W-1:0] pcc_top_i,
  input  logic             pcc_perm_ex_i,
  input  logic [XLEN-1:0]  addr_i,
  input  logic             is_compressed_i,
  output logic             bound_vio_o,
  output logic             acc_vio_o
);

  // one extra bit catches an address above the top
  logic [TOP_W:0] hdrm;
  logic           hdrm_ge4;
  logic           hdrm_ge2;
  logic           hdrm_ok;
  logic           base_ok;
  logic           allow_all;

  // whole address space, lets a word fetch at 0xffff_fffe wrap
  assign allow_all = (pcc_base_i == '0) && (pcc_top_i == {1'b1, {XLEN{1'b0}}});

  // bytes left between the fetch address and the top
  assign hdrm = {1'b0, pcc_top_i} - {2'b00, addr_i};

  // negative headroom has the top bit set
  assign hdrm_ge4 = ~hdrm[TOP_W] & (|hdrm[TOP_W-1:2]);
  assign hdrm_ge2 = ~hdrm[TOP_W] & (|hdrm[TOP_W-1:1]);

  // compressed fetches need two bytes, full words four
  assign hdrm_ok = is_compressed_i ? hdrm_ge2 : hdrm_ge4;
  assign base_ok = (addr_i >= pcc_base_i);

  assign bound_vio_o = cheri_pmode_i & ~allow_all & (~base_ok | ~hdrm_ok);

  // pcc must carry execute permission
  assign acc_vio_o = cheri_pmode_i & ~pcc_perm_ex_i;

endmodule

// ==== design/if_id_reg.sv ====
////////////////////////////////////////
// IF-ID pipeline register with one entry
// valid/ready toward fetch and decode
// flush drops the entry and any item loading in that cycle
////////////////////////////////////////

module if_id_reg import if_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  logic            in_valid_i,
  input  logic [XLEN-1:0] in_instr_i,
  input  logic            in_is_compressed_i,
  input  logic            in_illegal_i,
  input  logic [XLEN-1:0] in_pc_i,
  input  logic            in_err_i,
  input  logic            id_ready_i,
  output logic            in_ready_o,
  output logic            id_valid_o,
  output logic [XLEN-1:0] id_instr_o,
  output logic            id_is_compressed_o,
  output logic            id_illegal_c_o,
  output logic [XLEN-1:0] id_pc_o,
  output logic            id_fetch_err_o
);

  logic load;

  // free when empty or when decode drains the entry this cycle
  assign in_ready_o = ~id_valid_o | id_ready_i;

  // an item arriving with a flush is thrown away
  assign load = in_valid_i & in_ready_o & ~flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_valid_o <= 1'b0;
    end else if (flush_i) begin
      id_valid_o <= 1'b0;
    end else if (load) begin
      id_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      // drained with nothing new behind it
      id_valid_o <= 1'b0;
    end
  end

  // payload only moves on a load so it holds under back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_instr_o         <= '0;
      id_is_compressed_o <= 1'b0;
      id_illegal_c_o     <= 1'b0;
      id_pc_o            <= '0;
      id_fetch_err_o     <= 1'b0;
    end else if (load) begin
      id_instr_o         <= in_instr_i;
      id_is_compressed_o <= in_is_compressed_i;
      id_illegal_c_o     <= in_illegal_i;
      id_pc_o            <= in_pc_i;
      id_fetch_err_o     <= in_err_i;
    end
  end

  // a stalled entry stays valid and unchanged until decode takes it
  stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    id_valid_o && !id_ready_i && !flush_i |=> id_valid_o &&
    $stable({id_instr_o, id_is_compressed_o, id_illegal_c_o, id_pc_o, id_fetch_err_o}));

endmodule

// ==== design/if_stage.sv ====
////////////////////////////////////////
// instruction fetch stage top level
// expands and checks each fetched word, registers it for decode
// and drives the redirect address on a PC set
////////////////////////////////////////

module if_stage import if_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  // PC control
  input  logic             pc_set_i,
  input  pc_sel_e          pc_mux_i,
  input  logic [XLEN-1:0]  boot_addr_i,
  input  logic [XLEN-1:0]  branch_target_i,
  input  logic [XLEN-1:0]  csr_mepc_i,
  input  logic [XLEN-1:0]  csr_mtvec_i,
  // capability inputs
  input  logic             cheri_pmode_i,
  input  logic [XLEN-1:0]  pcc_base_i,
  input  logic [TOP_W-1:0] pcc_top_i,
  input  logic             pcc_perm_ex_i,
  // fetch side
  input  logic             fetch_valid_i,
  output logic             fetch_ready_o,
  input  logic [XLEN-1:0]  fetch_rdata_i,
  input  logic [XLEN-1:0]  fetch_addr_i,
  input  logic             fetch_err_i,
  // decode side
  output logic             id_valid_o,
  input  logic             id_ready_i,
  output logic [XLEN-1:0]  id_instr_o,
  output logic             id_is_compressed_o,
  output logic             id_illegal_c_o,
  output logic [XLEN-1:0]  id_pc_o,
  output logic             id_fetch_err_o,
  // redirect
  output logic             redirect_o,
  output logic [XLEN-1:0]  redirect_addr_o,
  output logic             csr_mtvec_init_o
);

  logic [XLEN-1:0] instr_exp;
  logic            is_compressed;
  logic            illegal_c;
  logic            bound_vio;
  logic            acc_vio;
  logic            fetch_err;

  next_pc_sel i_next_pc_sel (
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .redirect_o      (redirect_o),
    .redirect_addr_o (redirect_addr_o),
    .csr_mtvec_init_o(csr_mtvec_init_o)
  );

  // decode step
  c_expander i_c_expander (
    .instr_i        (fetch_rdata_i),
    .instr_o        (instr_exp),
    .is_compressed_o(is_compressed),
    .illegal_o      (illegal_c)
  );

  // execute step, the length comes from the expander
  pcc_bounds_check i_pcc_bounds_check (
    .cheri_pmode_i  (cheri_pmode_i),
    .pcc_base_i     (pcc_base_i),
    .pcc_top_i      (pcc_top_i),
    .pcc_perm_ex_i  (pcc_perm_ex_i),
    .addr_i         (fetch_addr_i),
    .is_compressed_i(is_compressed),
    .bound_vio_o    (bound_vio),
    .acc_vio_o      (acc_vio)
  );

  // bus error and both capability faults share one error bit
  assign fetch_err = fetch_err_i | bound_vio | acc_vio;

  // result step, a PC set squashes whatever is in flight
  if_id_reg i_if_id_reg (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (pc_set_i),
    .in_valid_i        (fetch_valid_i),
    .in_instr_i        (instr_exp),
    .in_is_compressed_i(is_compressed),
    .in_illegal_i      (illegal_c),
    .in_pc_i           (fetch_addr_i),
    .in_err_i          (fetch_err),
    .id_ready_i        (id_ready_i),
    .in_ready_o        (fetch_ready_o),
    .id_valid_o        (id_valid_o),
    .id_instr_o        (id_instr_o),
    .id_is_compressed_o(id_is_compressed_o),
    .id_illegal_c_o    (id_illegal_c_o),
    .id_pc_o           (id_pc_o),
    .id_fetch_err_o    (id_fetch_err_o)
  );

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // PC source select must be known when the core sets the PC
  pc_mux_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> !$isunknown(pc_mux_i));

  // boot region is aligned like the trap vector
  boot_addr_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    boot_addr_i[VEC_ALIGN_BITS-1:0] == '0);

  // accepted item reaches decode one cycle later unless squashed
  fetch_to_id_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && fetch_ready_o && !pc_set_i |=> id_valid_o && id_pc_o == $past(fetch_addr_i));

endmodule

// ==== verif/tb_clock_gen.sv ====
////////////////////////////////////////
// clock and reset source for the fetch stage testbench
// 10 unit period, reset held low for the first 3 cycles
////////////////////////////////////////

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    // release on an edge without racing the flops
    rst_no <= 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

// ==== verif/if_stage_tb.sv ====
////////////////////////////////////////
// testbench for the fetch stage, drives a table of fetch items
// with random decode back-pressure, then checks redirect and squash
////////////////////////////////////////

module if_stage_tb import if_pkg::*; ;

  localparam logic [31:0] LCG_SEED        = 32'hbfa3103a;
  localparam int unsigned CYCLES_PER_ITEM = 20;
  localparam int unsigned TIMEOUT_MARGIN  = 100;

  // one fetch item with its capability context and expected decode outputs
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] addr;
    logic        ferr;
    logic        pmode;
    logic [31:0] base;
    logic [32:0] top;
    logic        perm;
    logic [31:0] exp_instr;
    logic        exp_c;
    logic        exp_ill;
    logic        exp_err;
  } item_t;

  logic clk_i;
  logic rst_ni;

  logic             pc_set_i;
  pc_sel_e          pc_mux_i;
  logic [XLEN-1:0]  boot_addr_i;
  logic [XLEN-1:0]  branch_target_i;
  logic [XLEN-1:0]  csr_mepc_i;
  logic [XLEN-1:0]  csr_mtvec_i;
  logic             cheri_pmode_i;
  logic [XLEN-1:0]  pcc_base_i;
  logic [TOP_W-1:0] pcc_top_i;
  logic             pcc_perm_ex_i;
  logic             fetch_valid_i;
  logic             fetch_ready_o;
  logic [XLEN-1:0]  fetch_rdata_i;
  logic [XLEN-1:0]  fetch_addr_i;
  logic             fetch_err_i;
  logic             id_valid_o;
  logic             id_ready_i;
  logic [XLEN-1:0]  id_instr_o;
  logic             id_is_compressed_o;
  logic             id_illegal_c_o;
  logic [XLEN-1:0]  id_pc_o;
  logic             id_fetch_err_o;
  logic             redirect_o;
  logic [XLEN-1:0]  redirect_addr_o;
  logic             csr_mtvec_init_o;

  item_t       table_q[$];
  item_t       exp_q[$];
  item_t       exp_item;
  logic        cur_pmode;
  logic [31:0] cur_base;
  logic [32:0] cur_top;
  logic        cur_perm;
  logic [31:0] lcg_state = LCG_SEED;
  logic        random_ready = 1'b0;
  logic        held = 1'b0;
  logic [66:0] held_bits;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 1000;

  tb_clock_gen i_tb_clock_gen (
    .clk_o (clk_i),
    .rst_no(rst_ni)
  );

  if_stage i_if_stage (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .pc_set_i(pc_set_i), .pc_mux_i(pc_mux_i), .boot_addr_i(boot_addr_i),
    .branch_target_i(branch_target_i), .csr_mepc_i(csr_mepc_i), .csr_mtvec_i(csr_mtvec_i),
    .cheri_pmode_i(cheri_pmode_i), .pcc_base_i(pcc_base_i), .pcc_top_i(pcc_top_i),
    .pcc_perm_ex_i(pcc_perm_ex_i),
    .fetch_valid_i(fetch_valid_i), .fetch_ready_o(fetch_ready_o),
    .fetch_rdata_i(fetch_rdata_i), .fetch_addr_i(fetch_addr_i), .fetch_err_i(fetch_err_i),
    .id_valid_o(id_valid_o), .id_ready_i(id_ready_i), .id_instr_o(id_instr_o),
    .id_is_compressed_o(id_is_compressed_o), .id_illegal_c_o(id_illegal_c_o),
    .id_pc_o(id_pc_o), .id_fetch_err_o(id_fetch_err_o),
    .redirect_o(redirect_o), .redirect_addr_o(redirect_addr_o),
    .csr_mtvec_init_o(csr_mtvec_init_o)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
    stop_run();
  endtask

  // capability context for the items added after it
  task automatic set_cap(input logic pmode, input logic [31:0] base, input logic [32:0] top,
                         input logic perm);
    cur_pmode = pmode;
    cur_base  = base;
    cur_top   = top;
    cur_perm  = perm;
  endtask

  task automatic add_item(input logic [31:0] instr, input logic [31:0] addr, input logic ferr,
                          input logic [31:0] exp_instr, input logic exp_c, input logic exp_ill,
                          input logic exp_err);
    table_q.push_back({instr, addr, ferr, cur_pmode, cur_base, cur_top, cur_perm,
                       exp_instr, exp_c, exp_ill, exp_err});
  endtask

  task automatic build_table();
    // instr, addr, fetch_err, expected instr, compressed, illegal, error
    set_cap(1'b0, 32'h0, 33'h0, 1'b0);
    add_item(32'h0000_0085, 32'h0000_0100, 1'b0, 32'h0010_8093, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_157d, 32'h0000_0102, 1'b0, 32'hfff5_0513, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_429d, 32'h0000_0104, 1'b0, 32'h0070_0293, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_6185, 32'h0000_0106, 1'b0, 32'h0000_11b7, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_8426, 32'h0000_0108, 1'b0, 32'h0090_0433, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_9426, 32'h0000_010a, 1'b0, 32'h0094_0433, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_a021, 32'h0000_010c, 1'b0, 32'h0080_006f, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_bffd, 32'h0000_010e, 1'b0, 32'hffff_f06f, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_4044, 32'h0000_0110, 1'b0, 32'h0044_2483, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_c588, 32'h0000_0112, 1'b0, 32'h00a5_a423, 1'b1, 1'b0, 1'b0);
    // zero halfword, c.lui to sp, c.jr, c.addi4spn stay as fetched
    add_item(32'h0000_0000, 32'h0000_0114, 1'b0, 32'h0000_0000, 1'b1, 1'b1, 1'b0);
    add_item(32'h0000_6105, 32'h0000_0116, 1'b0, 32'h0000_6105, 1'b1, 1'b1, 1'b0);
    add_item(32'h0000_8082, 32'h0000_0118, 1'b0, 32'h0000_8082, 1'b1, 1'b1, 1'b0);
    add_item(32'h0000_0040, 32'h0000_011a, 1'b0, 32'h0000_0040, 1'b1, 1'b1, 1'b0);
    // full words
    add_item(32'h0050_0093, 32'h0000_0120, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b0);
    add_item(32'hdead_beef, 32'h0000_0124, 1'b0, 32'hdead_beef, 1'b0, 1'b0, 1'b0);
    // bounds 0x1000..0x2000
    set_cap(1'b1, 32'h0000_1000, 33'h0_0000_2000, 1'b1);
    add_item(32'h0050_0093, 32'h0000_1000, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b0);
    add_item(32'h0050_0093, 32'h0000_0ffc, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b1);
    add_item(32'h0050_0093, 32'h0000_1ffc, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b0);
    add_item(32'h0050_0093, 32'h0000_1ffe, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b1);
    add_item(32'h0000_0085, 32'h0000_1ffe, 1'b0, 32'h0010_8093, 1'b1, 1'b0, 1'b0);
    add_item(32'h0000_0085, 32'h0000_1fff, 1'b0, 32'h0010_8093, 1'b1, 1'b0, 1'b1);
    add_item(32'h0050_0093, 32'h0000_3000, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b1);
    // no execute permission
    set_cap(1'b1, 32'h0000_1000, 33'h0_0000_2000, 1'b0);
    add_item(32'h0050_0093, 32'h0000_1000, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b1);
    // whole address space
    set_cap(1'b1, 32'h0000_0000, 33'h1_0000_0000, 1'b1);
    add_item(32'h0050_0093, 32'hffff_fffe, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b0);
    add_item(32'h0050_0093, 32'h0000_0000, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b0);
    // bad bounds ignored outside capability mode
    set_cap(1'b0, 32'h0000_1000, 33'h0_0000_2000, 1'b0);
    add_item(32'h0050_0093, 32'h0000_0ffc, 1'b0, 32'h0050_0093, 1'b0, 1'b0, 1'b0);
    add_item(32'h0050_0093, 32'h0000_0200, 1'b1, 32'h0050_0093, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic drive_item(input item_t it);
    fetch_valid_i <= 1'b1;
    fetch_rdata_i <= it.instr;
    fetch_addr_i  <= it.addr;
    fetch_err_i   <= it.ferr;
    cheri_pmode_i <= it.pmode;
    pcc_base_i    <= it.base;
    pcc_top_i     <= it.top;
    pcc_perm_ex_i <= it.perm;
    do @(negedge clk_i); while (!fetch_ready_o);
    @(posedge clk_i);
    exp_q.push_back(it);
  endtask

  task automatic check_redirect(input pc_sel_e sel, input logic [31:0] want);
    assert (redirect_o) else report_mismatch("redirect_o", 32'(redirect_o), 32'd1);
    assert (redirect_addr_o == want)
      else report_mismatch("redirect_addr_o", redirect_addr_o, want);
    assert (csr_mtvec_init_o == (sel == PC_BOOT))
      else report_mismatch("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(sel == PC_BOOT));
  endtask

  // held item squashed by one pulse, item accepted with a second pulse
  task automatic squash_check(input pc_sel_e sel, input logic [31:0] want);
    @(posedge clk_i);
    fetch_valid_i <= 1'b1;
    fetch_rdata_i <= 32'h0050_0093;
    fetch_addr_i  <= 32'h0000_2100;
    fetch_err_i   <= 1'b0;
    cheri_pmode_i <= 1'b0;
    do @(negedge clk_i); while (!fetch_ready_o);
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    pc_set_i      <= 1'b1;
    pc_mux_i      <= sel;
    @(negedge clk_i);
    assert (id_valid_o) else report_error("item was not held before the PC set");
    check_redirect(sel, want);
    @(posedge clk_i);
    pc_set_i <= 1'b0;
    @(negedge clk_i);
    assert (!id_valid_o) else report_error("held item survived the PC set");
    assert (!redirect_o && !csr_mtvec_init_o)
      else report_error("redirect outputs high without a PC set");
    @(posedge clk_i);
    fetch_valid_i <= 1'b1;
    fetch_addr_i  <= 32'h0000_2200;
    pc_set_i      <= 1'b1;
    @(negedge clk_i);
    assert (fetch_ready_o) else report_error("fetch not ready on an empty register");
    check_redirect(sel, want);
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    pc_set_i      <= 1'b0;
    @(negedge clk_i);
    assert (!id_valid_o) else report_error("item accepted with the PC set reached decode");
  endtask

  ////////////////////////////////////////
  // decode back-pressure, checker, timeout
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    lcg_state  <= lcg_next(lcg_state);
    id_ready_i <= random_ready & lcg_state[16];
  end

  // sampled mid-cycle, a transfer seen here happens at the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (held) begin
        assert (id_valid_o && held_bits == {id_instr_o, id_is_compressed_o, id_illegal_c_o,
                                            id_pc_o, id_fetch_err_o})
          else report_error("decode outputs changed while id_ready_i was low");
      end
      held      = id_valid_o && !id_ready_i && !pc_set_i;
      held_bits = {id_instr_o, id_is_compressed_o, id_illegal_c_o, id_pc_o, id_fetch_err_o};
      if (id_valid_o && id_ready_i) begin
        if (exp_q.size() == 0) begin
          report_error("decode received an item that was never expected");
        end else begin
          exp_item = exp_q.pop_front();
          assert (id_instr_o == exp_item.exp_instr)
            else report_mismatch("id_instr_o", id_instr_o, exp_item.exp_instr);
          assert (id_pc_o == exp_item.addr)
            else report_mismatch("id_pc_o", id_pc_o, exp_item.addr);
          assert (id_is_compressed_o == exp_item.exp_c)
            else report_mismatch("id_is_compressed_o", 32'(id_is_compressed_o),
                                 32'(exp_item.exp_c));
          assert (id_illegal_c_o == exp_item.exp_ill)
            else report_mismatch("id_illegal_c_o", 32'(id_illegal_c_o), 32'(exp_item.exp_ill));
          assert (id_fetch_err_o == exp_item.exp_err)
            else report_mismatch("id_fetch_err_o", 32'(id_fetch_err_o), 32'(exp_item.exp_err));
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      report_error($sformatf("timeout after %0d cycles", cycle_count));
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    pc_set_i        = 1'b0;
    pc_mux_i        = PC_BOOT;
    boot_addr_i     = 32'h2000_0000;
    branch_target_i = 32'h0000_1234;
    csr_mepc_i      = 32'h0000_8888;
    csr_mtvec_i     = 32'h0000_45ab;
    cheri_pmode_i   = 1'b0;
    pcc_base_i      = '0;
    pcc_top_i       = '0;
    pcc_perm_ex_i   = 1'b0;
    fetch_valid_i   = 1'b0;
    fetch_rdata_i   = '0;
    fetch_addr_i    = '0;
    fetch_err_i     = 1'b0;
    id_ready_i      = 1'b0;
    build_table();
    cycle_limit = CYCLES_PER_ITEM * table_q.size() + TIMEOUT_MARGIN;
    @(posedge rst_ni);
    // reset releases after this edge's back-pressure update
    random_ready = 1'b1;
    @(posedge clk_i);
    foreach (table_q[i]) begin
      drive_item(table_q[i]);
    end
    fetch_valid_i <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    // decode stalls from here, nothing may reach it
    random_ready = 1'b0;
    squash_check(PC_BOOT, 32'h2000_0080);
    squash_check(PC_JUMP, 32'h0000_1234);
    squash_check(PC_EXC,  32'h0000_4500);
    squash_check(PC_ERET, 32'h0000_8888);
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== files.f ====
design/if_pkg.sv
design/next_pc_sel.sv
design/c_expander.sv
design/pcc_bounds_check.sv
design/if_id_reg.sv
design/if_stage.sv
verif/tb_clock_gen.sv
verif/if_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the fetch stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module if_stage_tb -o if_stage_sim

# the pipe keeps the log even when the run stops with $fatal
./obj_dir/if_stage_sim | tee sim.log

# pass only when the testbench reported success
grep -q "all tests passed" sim.log
